// File: testbench/imul_stimulus.txt
# name a_hex b_hex is_signed expected_product_hex
# one test per line, is_signed is 0 or 1
u_small     00000003 00000005 0 000000000000000F
u_zero_a    00000000 12345678 0 0000000000000000
u_zero_b    DEADBEEF 00000000 0 0000000000000000
u_one       00000001 DEADBEEF 0 00000000DEADBEEF
u_hex       00000100 00000100 0 0000000000010000
u_ffff      0000FFFF 0000FFFF 0 00000000FFFE0001
u_shift     00010000 00010000 0 0000000100000000
u_top_bit   80000000 00000002 0 0000000100000000
u_mid       12345678 00000010 0 0000000123456780
u_ones      FFFFFFFF FFFFFFFF 0 FFFFFFFE00000001
s_pos_pos   00000007 00000006 1 000000000000002A
s_neg_pos   FFFFFFFD 00000005 1 FFFFFFFFFFFFFFF1
s_pos_neg   00000005 FFFFFFFD 1 FFFFFFFFFFFFFFF1
s_neg_neg   FFFFFFFD FFFFFFFB 1 000000000000000F
s_neg_small FFFFFFFE 00000040 1 FFFFFFFFFFFFFF80
s_m1_m1     FFFFFFFF FFFFFFFF 1 0000000000000001
s_min_1     80000000 00000001 1 FFFFFFFF80000000
s_min_m1    80000000 FFFFFFFF 1 0000000080000000
s_min_min   80000000 80000000 1 4000000000000000
s_max_max   7FFFFFFF 7FFFFFFF 1 3FFFFFFF00000001
s_zero_neg  00000000 FFFFFFFF 1 0000000000000000
f_neg_pos   FFFFFFFD 00000005 0 00000004FFFFFFF1
f_neg_neg   FFFFFFFD FFFFFFFB 0 FFFFFFF80000000F
f_m1_m1     FFFFFFFF FFFFFFFF 0 FFFFFFFE00000001
f_min_1     80000000 00000001 0 0000000080000000
f_min_m1    80000000 FFFFFFFF 0 7FFFFFFF80000000
f_neg_small FFFFFFFE 00000040 0 0000003FFFFFFF80

// File: imul_iter.f
rtl/imul_pkg.sv
rtl/imul_req_side.sv
rtl/imul_ctrl.sv
rtl/imul_dpath.sv
rtl/imul_resp_side.sv
rtl/imul_top.sv
testbench/imul_properties.sv
testbench/imul_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the imul_iter simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal -j 0 \
  --top-module imul_tb \
  -f imul_iter.f

# the run may end with a nonzero status on an assertion, the search decides
status=0
out=$(./obj_dir/Vimul_tb 2>&1) || status=$?
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
  echo "run_sim: passed"
  exit 0
fi

echo "run_sim: failed (simulator status $status)"
exit 1

// File: testbench/imul_tb.sv
/*
  testbench for imul_top: stimulus file reader, request driver,
  response checker with random ack delay, timeout and summary
*/

`timescale 1ns/1ps

module imul_tb import imul_pkg::*; ();

  localparam int MAX_TESTS  = 64;
  localparam int NAME_CHARS = 24;
  localparam int LINE_CHARS = 128;

  logic      clk;
  logic      reset;
  logic      req;
  mul_req_t  req_msg;
  logic      ack;
  logic      resp_req;
  mul_resp_t resp_msg;
  logic      resp_ack;

  // test table, filled from the stimulus file
  logic [8*NAME_CHARS-1:0] t_name [MAX_TESTS];
  mul_req_t                t_req  [MAX_TESTS];
  product_t                t_exp  [MAX_TESTS];
  int                      num_tests;

  // expected results in request order
  product_t                exp_q  [$];
  logic [8*NAME_CHARS-1:0] name_q [$];

  int     pass_cnt;
  int     fail_cnt;
  int     other_errors;
  int     cycle_cnt   = 0;
  int     cycle_limit = 100;
  integer seed;

  imul_top i_imul_top (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_msg  (req_msg),
    .ack      (ack),
    .resp_req (resp_req),
    .resp_msg (resp_msg),
    .resp_ack (resp_ack)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ----------------------------------------
  // stimulus file
  // ----------------------------------------

  task automatic read_stimulus();
    integer                  fd;
    integer                  code;
    integer                  n;
    logic [8*LINE_CHARS-1:0] line;
    logic [8*NAME_CHARS-1:0] name;
    operand_t                a;
    operand_t                b;
    logic [31:0]             sflag;
    product_t                exp_p;
    fd = $fopen("testbench/imul_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file testbench/imul_stimulus.txt");
      other_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        name = '0;
        code = $fgets(line, fd);
        if (code > 0) begin
          n = $sscanf(line, "%s %h %h %h %h", name, a, b, sflag, exp_p);
          // lines starting with # are comments, empty lines give n <= 0
          if (n > 0 && name != "#") begin
            if (n != 5) begin
              $display("malformed stimulus line: %0s", line);
              other_errors++;
            end else if (num_tests >= MAX_TESTS) begin
              $display("too many tests in the stimulus file, %0s dropped", name);
              other_errors++;
            end else begin
              t_name[num_tests] = name;
              t_req[num_tests]  = '{a: a, b: b, is_signed: sflag[0]};
              t_exp[num_tests]  = exp_p;
              num_tests++;
            end
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // ----------------------------------------
  // request driver
  // ----------------------------------------

  // four-phase request, called and left on a falling edge
  task automatic send_request(input mul_req_t msg);
    req_msg = msg;
    req     = 1'b1;
    do @(negedge clk); while (!ack);
    req = 1'b0;
    do @(negedge clk); while (ack);
  endtask

  task automatic drive_all();
    int i;
    for (i = 0; i < num_tests; i++) begin
      // queued before req goes up so the response always finds it
      exp_q.push_back(t_exp[i]);
      name_q.push_back(t_name[i]);
      send_request(t_req[i]);
    end
  endtask

  // ----------------------------------------
  // response checker
  // ----------------------------------------

  task automatic collect_responses();
    int                      k;
    int                      delay;
    product_t                got;
    product_t                want;
    logic [8*NAME_CHARS-1:0] nm;
    for (k = 0; k < num_tests; k++) begin
      do @(negedge clk); while (!resp_req);
      got = resp_msg.product;
      // hold-off of 0 to 56 cycles in steps of 8
      // anything longer than the compute time stalls the core in DONE
      delay = 8 * ($unsigned($random(seed)) % 8);
      repeat (delay) @(negedge clk);
      resp_ack = 1'b1;
      do @(negedge clk); while (resp_req);
      resp_ack = 1'b0;
      if (exp_q.size() == 0) begin
        $display("a response arrived with no request outstanding");
        other_errors++;
      end else begin
        want = exp_q.pop_front();
        nm   = name_q.pop_front();
        if (got !== want) begin
          $display("Fail %0s: expected %h, actual %h", nm, want, got);
          fail_cnt++;
        end else begin
          $display("Pass %0s: product %h", nm, got);
          pass_cnt++;
        end
      end
    end
  endtask

  task automatic check_reset_outputs(input string phase);
    if (ack !== 1'b0 || resp_req !== 1'b0) begin
      $display("ack or resp_req is not low %0s reset", phase);
      other_errors++;
    end
  endtask

  // ----------------------------------------
  // timeout
  // ----------------------------------------

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: tests did not finish within %0d cycles", cycle_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    reset        = 1'b1;
    req          = 1'b0;
    req_msg      = '0;
    resp_ack     = 1'b0;
    seed         = 32'h8488_a236;
    num_tests    = 0;
    pass_cnt     = 0;
    fail_cnt     = 0;
    other_errors = 0;

    read_stimulus();
    cycle_limit = num_tests * (NUM_STEPS + 30) + 100;

    // 8 cycles of reset, outputs checked near its end and right after
    repeat (7) @(negedge clk);
    check_reset_outputs("during");
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_reset_outputs("just after");

    fork
      drive_all();
      collect_responses();
    join

    if (exp_q.size() != 0) begin
      $display("%0d expected responses never arrived", exp_q.size());
      other_errors++;
    end

    $display("tests: %0d  passed: %0d  failed: %0d  other errors: %0d",
             num_tests, pass_cnt, fail_cnt, other_errors);
    if (fail_cnt == 0 && other_errors == 0 && num_tests > 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: testbench/imul_properties.sv
/*
  concurrent checks on the request and response four-phase handshakes
*/

`timescale 1ns/1ps

module imul_properties import imul_pkg::*; (
  input logic      clk,
  input logic      reset,
  input logic      req,
  input logic      ack,
  input logic      resp_req,
  input mul_resp_t resp_msg,
  input logic      resp_ack
);

  // ----------------------------------------
  // request port
  // ----------------------------------------

  // ack rises one edge after req was seen high
  ack_rise_on_req: assert property (@(posedge clk) disable iff (reset)
    $rose(ack) |-> $past(req))
    else $error("ack rose without a pending req");

  ack_held_while_req: assert property (@(posedge clk) disable iff (reset)
    (ack && req) |=> ack)
    else $error("ack fell while req was still high");

  // ----------------------------------------
  // response port
  // ----------------------------------------

  resp_msg_stable: assert property (@(posedge clk) disable iff (reset)
    (resp_req && $past(resp_req)) |-> $stable(resp_msg))
    else $error("resp_msg changed while resp_req was high");

  // req drops only on the edge after ack was sampled high
  resp_req_fall_after_ack: assert property (@(posedge clk) disable iff (reset)
    $fell(resp_req) |-> $past(resp_ack))
    else $error("resp_req fell before resp_ack rose");

endmodule

bind imul_top imul_properties i_props (
  .clk      (clk),
  .reset    (reset),
  .req      (req),
  .ack      (ack),
  .resp_req (resp_req),
  .resp_msg (resp_msg),
  .resp_ack (resp_ack)
);

// File: rtl/imul_top.sv
/*
  multiplier top: request side, control, datapath, response side
*/

`timescale 1ns/1ps

module imul_top import imul_pkg::*; (
  input  logic      clk,
  input  logic      reset,

  // request port
  input  logic      req,
  input  mul_req_t  req_msg,
  output logic      ack,

  // response port
  output logic      resp_req,
  output mul_resp_t resp_msg,
  input  logic      resp_ack
);

  // request buffer to core
  mul_req_t  buf_msg;
  logic      buf_full;
  logic      take;

  // core internals
  logic      load;
  logic      step;
  mul_resp_t result;

  // core to response buffer
  logic      hand_off;
  logic      out_full;

  imul_req_side i_req_side (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_msg  (req_msg),
    .ack      (ack),
    .take     (take),
    .buf_msg  (buf_msg),
    .buf_full (buf_full)
  );

  imul_ctrl i_ctrl (
    .clk      (clk),
    .reset    (reset),
    .buf_full (buf_full),
    .take     (take),
    .load     (load),
    .step     (step),
    .out_full (out_full),
    .hand_off (hand_off)
  );

  // operands come straight from the request buffer on load
  imul_dpath i_dpath (
    .clk     (clk),
    .reset   (reset),
    .load    (load),
    .step    (step),
    .req_msg (buf_msg),
    .result  (result)
  );

  imul_resp_side i_resp_side (
    .clk      (clk),
    .reset    (reset),
    .hand_off (hand_off),
    .result   (result),
    .out_full (out_full),
    .resp_req (resp_req),
    .resp_msg (resp_msg),
    .resp_ack (resp_ack)
  );

endmodule

// File: rtl/imul_resp_side.sv
/*
  response port driver: one-entry result buffer, four-phase req/ack
*/

`timescale 1ns/1ps

module imul_resp_side import imul_pkg::*; (
  input  logic      clk,
  input  logic      reset,

  // from the core
  input  logic      hand_off,
  input  mul_resp_t result,
  output logic      out_full,

  // external four-phase port
  output logic      resp_req,
  output mul_resp_t resp_msg,
  input  logic      resp_ack
);

  // return phase finished, ack has dropped after req fell
  logic release_buf;

  assign release_buf = out_full && !resp_req && !resp_ack;

  // ----------------------------------------
  // handshake sequencing
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      out_full <= 1'b0;
      resp_req <= 1'b0;
    end else begin
      // hand_off only comes while the buffer is empty
      if (hand_off) begin
        out_full <= 1'b1;
        resp_req <= 1'b1;
      end else if (resp_req && resp_ack) begin
        // phase two seen, drop req
        resp_req <= 1'b0;
      end else if (release_buf) begin
        out_full <= 1'b0;
      end
    end
  end

  // result held stable for the whole exchange
  always_ff @(posedge clk) begin
    if (hand_off) begin
      resp_msg <= result;
    end
  end

endmodule

// File: rtl/imul_dpath.sv
/*
  shift-and-add datapath: operand magnitudes, multiplicand and
  multiplier shift registers, accumulator, final sign fix-up
*/

`timescale 1ns/1ps

module imul_dpath import imul_pkg::*; (
  input  logic      clk,
  input  logic      reset,

  // control
  input  logic      load,
  input  logic      step,

  // operands from the request buffer
  input  mul_req_t  req_msg,

  // product, valid once all steps are done
  output mul_resp_t result
);

  // ----------------------------------------
  // operand conditioning
  // ----------------------------------------

  // effective sign: only counts for signed requests
  logic a_neg;
  logic b_neg;

  operand_t a_mag;
  operand_t b_mag;

  assign a_neg = req_msg.is_signed && req_msg.a[31];
  assign b_neg = req_msg.is_signed && req_msg.b[31];

  // two's complement magnitude
  // most negative value maps onto 2^31, still correct as unsigned
  assign a_mag = a_neg ? (~req_msg.a + 1'b1) : req_msg.a;
  assign b_mag = b_neg ? (~req_msg.b + 1'b1) : req_msg.b;

  // ----------------------------------------
  // iteration registers
  // ----------------------------------------

  // multiplicand is widened to 64 bits so it can shift left 31 times
  product_t mcand;
  operand_t mplier;
  product_t acc;
  logic     negate;

  // partial sum for this step
  product_t acc_next;

  assign acc_next = mplier[0] ? (acc + mcand) : acc;

  always_ff @(posedge clk) begin
    if (reset) begin
      acc    <= '0;
      negate <= 1'b0;
    end else if (load) begin
      acc    <= '0;
      // product is negative when exactly one operand is
      negate <= a_neg ^ b_neg;
    end else if (step) begin
      acc <= acc_next;
    end
  end

  // shift registers
  always_ff @(posedge clk) begin
    if (load) begin
      mcand  <= {32'b0, a_mag};
      mplier <= b_mag;
    end else if (step) begin
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // ----------------------------------------
  // result
  // ----------------------------------------

  always_comb begin
    result = '0;
    if (negate) begin
      result.product = ~acc + 1'b1;
    end else begin
      result.product = acc;
    end
  end

endmodule

// File: rtl/imul_ctrl.sv
/*
  control FSM: load from the request buffer, 32 compute steps,
  then hand the product to the response side
*/

`timescale 1ns/1ps

module imul_ctrl import imul_pkg::*; (
  input  logic clk,
  input  logic reset,

  // request buffer
  input  logic buf_full,
  output logic take,

  // datapath control
  output logic load,
  output logic step,

  // response buffer
  input  logic out_full,
  output logic hand_off
);

  ctrl_state_t state;
  step_cnt_t   step_cnt;

  // last compute step reached
  logic last_step;

  assign last_step = (step_cnt == step_cnt_t'(NUM_STEPS - 1));

  // ----------------------------------------
  // state register and step counter
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      step_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (buf_full) begin
            state    <= CALC;
            step_cnt <= '0;
          end
        end
        CALC: begin
          if (last_step) begin
            state <= DONE;
          end else begin
            step_cnt <= step_cnt + 1'b1;
          end
        end
        DONE: begin
          // waits here while the output buffer is still busy
          if (!out_full) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ----------------------------------------
  // outputs, decoded from state
  // ----------------------------------------

  always_comb begin
    take     = 1'b0;
    load     = 1'b0;
    step     = 1'b0;
    hand_off = 1'b0;
    case (state)
      IDLE: begin
        // datapath loads buf_msg in the same cycle the buffer is released
        take = buf_full;
        load = buf_full;
      end
      CALC:    step = 1'b1;
      DONE:    hand_off = !out_full;
      default: ;
    endcase
  end

endmodule

// File: rtl/imul_req_side.sv
/*
  request port receiver: four-phase req/ack with a one-entry buffer
*/

`timescale 1ns/1ps

module imul_req_side import imul_pkg::*; (
  input  logic     clk,
  input  logic     reset,

  // external four-phase port
  input  logic     req,
  input  mul_req_t req_msg,
  output logic     ack,

  // hand-off to the core
  input  logic     take,
  output mul_req_t buf_msg,
  output logic     buf_full
);

  // a new request is accepted only in phase one with room in the buffer
  logic accept;

  assign accept = req && !ack && !buf_full;

  // ----------------------------------------
  // handshake and buffer state
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      ack      <= 1'b0;
      buf_full <= 1'b0;
    end else begin
      // ack follows req: up on accept, down once req has dropped
      if (accept) begin
        ack <= 1'b1;
      end else if (!req && ack) begin
        ack <= 1'b0;
      end

      // take only happens while full, accept only while empty
      if (accept) begin
        buf_full <= 1'b1;
      end else if (take) begin
        buf_full <= 1'b0;
      end
    end
  end

  // payload capture
  always_ff @(posedge clk) begin
    if (accept) begin
      buf_msg <= req_msg;
    end
  end

endmodule

// File: rtl/imul_pkg.sv
/*
  shared types and constants for the iterative multiplier:
  operand/product widths, request/response structs, control states
*/

package imul_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------

  // one shift-and-add step per multiplier bit
  localparam int NUM_STEPS = 32;
  // counter covers 0 .. NUM_STEPS-1
  localparam int STEP_CNT_W = 5;

  // ----------------------------------------
  // value types
  // ----------------------------------------

  typedef logic [31:0] operand_t;
  typedef logic [63:0] product_t;
  typedef logic [STEP_CNT_W-1:0] step_cnt_t;

  // request payload, 65 bits
  typedef struct packed {
    operand_t a;
    operand_t b;
    logic is_signed;
  } mul_req_t;

  // response payload, room left for extra fields such as a tag
  typedef struct packed {
    product_t product;
  } mul_resp_t;

  // core sequencing states
  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } ctrl_state_t;

endpackage
